/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // byte address on the memory bus
  typedef logic [63:0] addr_t;

  // one fetched instruction
  typedef logic [31:0] inst_t;

  // one cache line as wide as a bus word
  typedef logic [63:0] line_t;

  // memory transaction tag where zero means no transaction
  typedef logic [3:0] mem_tag_t;

  // line index from address bits 7:3
  typedef logic [4:0] cache_idx_t;

  // line tag from address bits 15:8
  typedef logic [7:0] cache_tag_t;

  localparam int num_lines = 32;

  ////////////////////////////////////////
  // bus commands
  ////////////////////////////////////////

  typedef logic [1:0] bus_cmd_t;

  localparam bus_cmd_t bus_none = 2'd0;
  localparam bus_cmd_t bus_load = 2'd1;

  ////////////////////////////////////////
  // fill tracker states
  ////////////////////////////////////////

  typedef enum logic [0:0] {
    fill_idle = 1'b0,
    fill_wait = 1'b1
  } fill_state_e;

endpackage

`default_nettype wire

/* icache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_store (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::cache_idx_t rd_idx,
  input  fetch_pkg::cache_tag_t rd_tag,
  input  logic                  wr_en,
  input  fetch_pkg::cache_idx_t wr_idx,
  input  fetch_pkg::cache_tag_t wr_tag,
  input  fetch_pkg::line_t      wr_data,
  output fetch_pkg::line_t      rd_data,
  output logic                  rd_hit
);
  import fetch_pkg::*;

  // one valid bit, tag and data word per line
  logic       line_valid [num_lines];
  cache_tag_t line_tag   [num_lines];
  line_t      line_data  [num_lines];

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  // combinational lookup in the same cycle as the index
  assign rd_data = line_data[rd_idx];
  assign rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  // valid bit set by each fill
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_lines; i++) begin
        line_valid[i] <= 1'b0;
      end
    end else if (wr_en) begin
      line_valid[wr_idx] <= 1'b1;
    end
  end

  // tag and data written together with the valid bit
  always_ff @(posedge clock) begin
    if (wr_en) begin
      line_tag[wr_idx]  <= wr_tag;
      line_data[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* fill_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module fill_tracker (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::cache_idx_t miss_idx,
  input  fetch_pkg::cache_tag_t miss_tag,
  input  logic                  hit,
  input  fetch_pkg::mem_tag_t   mem2proc_response,
  input  fetch_pkg::mem_tag_t   mem2proc_tag,
  input  fetch_pkg::line_t      mem2proc_data,
  output fetch_pkg::bus_cmd_t   proc2mem_command,
  output fetch_pkg::addr_t      proc2mem_addr,
  output logic                  fill_en,
  output fetch_pkg::cache_idx_t fill_idx,
  output fetch_pkg::cache_tag_t fill_tag,
  output fetch_pkg::line_t      fill_data
);
  import fetch_pkg::*;

  fill_state_e state;
  fill_state_e state_next;

  // transaction in flight
  mem_tag_t    wait_resp;
  cache_idx_t  wait_idx;
  cache_tag_t  wait_tag;

  // requests start one cycle after reset is released
  logic        armed;

  logic        request;
  logic        accepted;
  logic        reply_match;

  ////////////////////////////////////////
  // bus request
  ////////////////////////////////////////

  assign request  = (state == fill_idle) && !hit && armed;
  assign accepted = request && (mem2proc_response != '0);

  assign proc2mem_command = request ? bus_load : bus_none;
  // line address is tag, index and three zero bits
  assign proc2mem_addr = request ? {48'b0, miss_tag, miss_idx, 3'b000} : '0;

  ////////////////////////////////////////
  // reply matching and fill
  ////////////////////////////////////////

  assign reply_match = (state == fill_wait) && (mem2proc_tag == wait_resp);

  assign fill_en   = reply_match;
  assign fill_idx  = wait_idx;
  assign fill_tag  = wait_tag;
  assign fill_data = mem2proc_data;

  always_comb begin
    state_next = state;
    unique case (state)
      fill_idle: begin
        // a refused request is simply asked again next cycle
        if (accepted) begin
          state_next = fill_wait;
        end
      end
      fill_wait: begin
        if (reply_match) begin
          state_next = fill_idle;
        end
      end
      default: state_next = fill_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= fill_idle;
      wait_resp <= '0;
      armed     <= 1'b0;
    end else begin
      state <= state_next;
      armed <= 1'b1;
      if (accepted) begin
        wait_resp <= mem2proc_response;
      end
    end
  end

  // line position of the outstanding request
  always_ff @(posedge clock) begin
    if (accepted) begin
      wait_idx <= miss_idx;
      wait_tag <= miss_tag;
    end
  end

endmodule

`default_nettype wire

/* fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc #(
  parameter fetch_pkg::addr_t reset_pc = '0
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  branch_taken,
  input  fetch_pkg::addr_t      branch_target,
  input  fetch_pkg::line_t      line_data,
  input  logic                  hit,
  output fetch_pkg::cache_idx_t lookup_idx,
  output fetch_pkg::cache_tag_t lookup_tag,
  output fetch_pkg::inst_t      inst,
  output fetch_pkg::addr_t      npc
);
  import fetch_pkg::*;

  addr_t pc;
  addr_t pc_next;
  addr_t pc_plus4;

  ////////////////////////////////////////
  // cache lookup
  ////////////////////////////////////////

  // index and tag straight from the PC
  assign lookup_idx = pc[7:3];
  assign lookup_tag = pc[15:8];

  // bit 2 picks the upper or lower instruction of the line
  assign inst = pc[2] ? line_data[63:32] : line_data[31:0];

  assign pc_plus4 = pc + 64'd4;
  assign npc      = pc_plus4;

  ////////////////////////////////////////
  // PC update
  ////////////////////////////////////////

  always_comb begin
    // redirect wins over stall and miss
    if (branch_taken) begin
      pc_next = branch_target;
    end else if (hit && !stall) begin
      pc_next = pc_plus4;
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* fetch_decode_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_reg (
  input  logic             clock,
  input  logic             reset,
  input  logic             stall,
  input  logic             branch_taken,
  input  fetch_pkg::inst_t inst,
  input  fetch_pkg::addr_t npc,
  input  logic             hit,
  output fetch_pkg::inst_t fetch_inst,
  output fetch_pkg::addr_t fetch_npc,
  output logic             fetch_valid
);
  import fetch_pkg::*;

  logic load;

  // new slot only when decode takes it and no redirect
  assign load = !stall && !branch_taken;

  ////////////////////////////////////////
  // valid bit
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_valid <= 1'b0;
    end else if (branch_taken) begin
      // wrong-path slot is dropped
      fetch_valid <= 1'b0;
    end else if (!stall) begin
      // a miss gives an empty slot
      fetch_valid <= hit;
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (load) begin
      fetch_inst <= inst_t'(inst);
      fetch_npc  <= npc;
    end
  end

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter fetch_pkg::addr_t reset_pc = '0
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                fetch_stall,
  input  logic                branch_taken,
  input  fetch_pkg::addr_t    branch_target,
  input  fetch_pkg::mem_tag_t mem2proc_response,
  input  fetch_pkg::mem_tag_t mem2proc_tag,
  input  fetch_pkg::line_t    mem2proc_data,
  output fetch_pkg::bus_cmd_t proc2mem_command,
  output fetch_pkg::addr_t    proc2mem_addr,
  output fetch_pkg::inst_t    fetch_inst,
  output fetch_pkg::addr_t    fetch_npc,
  output logic                fetch_valid
);
  import fetch_pkg::*;

  // lookup path
  cache_idx_t lookup_idx;
  cache_tag_t lookup_tag;
  line_t      line_data;
  logic       hit;

  // fill path
  logic       fill_en;
  cache_idx_t fill_idx;
  cache_tag_t fill_tag;
  line_t      fill_data;

  // fetched slot before the pipeline register
  inst_t      inst;
  addr_t      npc;

  ////////////////////////////////////////
  // cache and miss handling
  ////////////////////////////////////////

  icache_store u_icache_store (
    .clock   (clock),
    .reset   (reset),
    .rd_idx  (lookup_idx),
    .rd_tag  (lookup_tag),
    .wr_en   (fill_en),
    .wr_idx  (fill_idx),
    .wr_tag  (fill_tag),
    .wr_data (fill_data),
    .rd_data (line_data),
    .rd_hit  (hit)
  );

  fill_tracker u_fill_tracker (
    .clock             (clock),
    .reset             (reset),
    .miss_idx          (lookup_idx),
    .miss_tag          (lookup_tag),
    .hit               (hit),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fill_en           (fill_en),
    .fill_idx          (fill_idx),
    .fill_tag          (fill_tag),
    .fill_data         (fill_data)
  );

  ////////////////////////////////////////
  // PC and fetch/decode register
  ////////////////////////////////////////

  fetch_pc #(
    .reset_pc (reset_pc)
  ) u_fetch_pc (
    .clock         (clock),
    .reset         (reset),
    .stall         (fetch_stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .line_data     (line_data),
    .hit           (hit),
    .lookup_idx    (lookup_idx),
    .lookup_tag    (lookup_tag),
    .inst          (inst),
    .npc           (npc)
  );

  fetch_decode_reg u_fetch_decode_reg (
    .clock        (clock),
    .reset        (reset),
    .stall        (fetch_stall),
    .branch_taken (branch_taken),
    .inst         (inst),
    .npc          (npc),
    .hit          (hit),
    .fetch_inst   (fetch_inst),
    .fetch_npc    (fetch_npc),
    .fetch_valid  (fetch_valid)
  );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  logic                clock,
  input  logic                reset,
  input  logic [63:0]         rand_word,
  input  fetch_pkg::line_t    line_word,
  input  fetch_pkg::bus_cmd_t proc2mem_command,
  input  fetch_pkg::addr_t    proc2mem_addr,
  output fetch_pkg::mem_tag_t mem2proc_response,
  output fetch_pkg::mem_tag_t mem2proc_tag,
  output fetch_pkg::line_t    mem2proc_data,
  output fetch_pkg::addr_t    reply_addr
);
  import fetch_pkg::*;

  // one transaction at a time as issued by the fetch side
  logic     pending;
  mem_tag_t pend_tag;
  addr_t    pend_addr;
  int       wait_count;
  mem_tag_t next_response;

  // reply data is the hashed word of the saved line address
  assign mem2proc_data = line_word;

  initial begin
    pending           = 1'b0;
    pend_tag          = '0;
    pend_addr         = '0;
    wait_count        = 0;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    reply_addr        = '0;
  end

  always @(posedge clock) begin
    if (reset) begin
      pending = 1'b0;
    end else begin
      // reply shown in the cycle that just ended is done
      if (mem2proc_tag != '0) begin
        pending = 1'b0;
      end
      if ((proc2mem_command == bus_load) && (mem2proc_response != '0)) begin
        pending    = 1'b1;
        pend_tag   = mem2proc_response;
        pend_addr  = proc2mem_addr;
        // reply 1 to 8 cycles after the request
        wait_count = rand_word[14:12];
      end else if (pending && (wait_count > 0)) begin
        wait_count = wait_count - 1;
      end
    end
    // refuse about a third of the time
    if (reset || (rand_word[7:0] % 3 == 0)) begin
      next_response = '0;
    end else if (rand_word[11:8] == '0) begin
      next_response = 4'd1;
    end else begin
      next_response = rand_word[11:8];
    end
    #1;
    mem2proc_response = next_response;
    mem2proc_tag      = (pending && (wait_count == 0)) ? pend_tag : '0;
    reply_addr        = pend_addr;
  end

endmodule

`default_nettype wire

/* tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int          test_cycles = 2000;
  localparam int          cycle_limit = 10 * test_cycles;
  localparam logic [63:0] seed        = 64'd89;

  logic     clock;
  logic     reset;
  logic     fetch_stall;
  logic     branch_taken;
  addr_t    branch_target;
  mem_tag_t mem2proc_response;
  mem_tag_t mem2proc_tag;
  line_t    mem2proc_data;
  bus_cmd_t proc2mem_command;
  addr_t    proc2mem_addr;
  inst_t    fetch_inst;
  addr_t    fetch_npc;
  logic     fetch_valid;

  logic [63:0] rng;
  logic [63:0] mem_rand;
  addr_t       reply_addr;
  line_t       line_word;
  int          cycle_count = 0;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  addr_t      exp_pc;
  logic       exp_valid;
  logic       armed;
  logic       shadow_valid [num_lines];
  cache_tag_t shadow_tag   [num_lines];
  logic       outstanding;
  mem_tag_t   out_resp;
  addr_t      out_addr;
  logic       refused;
  addr_t      refused_addr;
  // slot history for the stall and redirect rules
  logic       hold_expected;
  logic       after_branch;
  inst_t      prev_inst;
  addr_t      prev_npc;
  addr_t      last_npc;
  logic       redirect_pending;
  addr_t      redirect_target;

  fetch_top #(
    .reset_pc (64'd0)
  ) u_dut (
    .clock             (clock),
    .reset             (reset),
    .fetch_stall       (fetch_stall),
    .branch_taken      (branch_taken),
    .branch_target     (branch_target),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fetch_inst        (fetch_inst),
    .fetch_npc         (fetch_npc),
    .fetch_valid       (fetch_valid)
  );

  tb_mem_model u_mem (
    .clock             (clock),
    .reset             (reset),
    .rand_word         (mem_rand),
    .line_word         (line_word),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .reply_addr        (reply_addr)
  );

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  // memory contents as a hash of the whole line address
  function automatic line_t line_hash(input addr_t a);
    return xorshift(xorshift(a ^ 64'h5bd1e995c3a2f107));
  endfunction

  function automatic inst_t mem_inst(input addr_t a);
    line_t word;
    word = line_hash({a[63:3], 3'b000});
    return a[2] ? word[63:32] : word[31:0];
  endfunction

  function automatic logic shadow_hit(input addr_t a);
    return shadow_valid[a[7:3]] && (shadow_tag[a[7:3]] == a[15:8]);
  endfunction

  assign line_word = line_hash(reply_addr);

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "check %s failed", name);
    end
  endtask

  task automatic clear_model();
    exp_pc           = '0;
    exp_valid        = 1'b0;
    armed            = 1'b0;
    outstanding      = 1'b0;
    refused          = 1'b0;
    hold_expected    = 1'b0;
    after_branch     = 1'b0;
    last_npc         = '0;
    redirect_pending = 1'b0;
    for (int i = 0; i < num_lines; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i]   = '0;
    end
  endtask

  task automatic drive_inputs();
    rng           = xorshift(rng);
    fetch_stall   = (rng[1:0] == 2'b00);
    branch_taken  = (rng[9:5] == 5'd0);
    // aligned target low enough that a straight run stays below 64 KiB
    branch_target = {49'b0, rng[30:18], 2'b00};
    rng           = xorshift(rng);
    mem_rand      = rng;
  endtask

  ////////////////////////////////////////
  // per-cycle check and model step
  ////////////////////////////////////////

  task automatic model_cycle();
    logic  hit;
    logic  request;
    addr_t pc_line;
    addr_t exp_npc;
    pc_line = {exp_pc[63:3], 3'b000};
    hit     = shadow_hit(exp_pc);
    request = armed && !outstanding && !hit;

    if (after_branch) begin
      check_value("redirect_squash", 1'b0, fetch_valid);
    end
    check_value("fetch_valid", exp_valid, fetch_valid);
    if (hold_expected) begin
      check_value("stall_hold_inst", prev_inst, fetch_inst);
      check_value("stall_hold_npc", prev_npc, fetch_npc);
    end
    if (fetch_valid) begin
      // a held slot is not a new output
      if (!hold_expected) begin
        if (redirect_pending) begin
          exp_npc = redirect_target + 64'd4;
          check_value("redirect_npc", exp_npc, fetch_npc);
        end else begin
          exp_npc = last_npc + 64'd4;
          check_value("sequential_npc", exp_npc, fetch_npc);
        end
        last_npc         = exp_npc;
        redirect_pending = 1'b0;
      end
      check_value("fetch_inst", mem_inst(last_npc - 64'd4), fetch_inst);
    end

    if (outstanding) begin
      check_value("single_outstanding", bus_none, proc2mem_command);
    end
    if (proc2mem_command == bus_load) begin
      check_value("cache_reuse", 1'b0, shadow_hit(proc2mem_addr));
    end
    if (refused) begin
      check_value("retry_command", bus_load, proc2mem_command);
      check_value("retry_addr", refused_addr, proc2mem_addr);
    end
    check_value("bus_command", request ? bus_load : bus_none, proc2mem_command);
    if (request) begin
      check_value("bus_addr", pc_line, proc2mem_addr);
    end

    // state at the coming edge
    if (request && (mem2proc_response != '0)) begin
      outstanding = 1'b1;
      out_resp    = mem2proc_response;
      out_addr    = pc_line;
    end else if (outstanding && (mem2proc_tag == out_resp)) begin
      shadow_valid[out_addr[7:3]] = 1'b1;
      shadow_tag[out_addr[7:3]]   = out_addr[15:8];
      outstanding                 = 1'b0;
    end
    refused       = request && (mem2proc_response == '0) && !branch_taken;
    refused_addr  = pc_line;
    hold_expected = fetch_stall && !branch_taken;
    after_branch  = branch_taken;
    prev_inst     = fetch_inst;
    prev_npc      = fetch_npc;
    armed         = 1'b1;
    if (branch_taken) begin
      exp_valid        = 1'b0;
      exp_pc           = branch_target;
      redirect_pending = 1'b1;
      redirect_target  = branch_target;
    end else if (!fetch_stall) begin
      exp_valid = hit;
      if (hit) begin
        exp_pc = exp_pc + 64'd4;
      end
    end
  endtask

  ////////////////////////////////////////
  // clock, run control and timeout
  ////////////////////////////////////////

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rng           = seed;
    reset         = 1'b1;
    fetch_stall   = 1'b0;
    branch_taken  = 1'b0;
    branch_target = '0;
    mem_rand      = '0;
    clear_model();
    repeat (5) begin
      @(posedge clock);
      #1;
      check_value("reset_valid", 1'b0, fetch_valid);
      check_value("reset_command", bus_none, proc2mem_command);
    end
    reset = 1'b0;
    drive_inputs();
    for (int n = 0; n < test_cycles; n++) begin
      // everything is settled by the falling edge
      @(negedge clock);
      model_cycle();
      @(posedge clock);
      #1;
      drive_inputs();
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
fetch_pkg.sv
icache_store.sv
fill_tracker.sv
fetch_pc.sv
fetch_decode_reg.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch_top.sv
